/* compile.f */
rtl/exec_pkg.sv
rtl/exec_alu.sv
rtl/branch_resolve.sv
rtl/load_align.sv
rtl/exec_ctrl.sv
rtl/exec_unit.sv
tests/exec_checker.sv
tests/tb_exec_unit.sv

/* Makefile */
# Verilator build and run for the execute stage testbench

SIM := obj_dir/Vtb_exec_unit

$(SIM): compile.f $(shell cat compile.f)
	verilator --binary --timing --assert --top-module tb_exec_unit \
		-f compile.f -o Vtb_exec_unit

run: $(SIM)
	$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "sim failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* tests/tb_exec_unit.sv */
`timescale 1ns/1ps

module tb_exec_unit;

    // far above the length of all tests
    localparam int max_cycles = 2000;

    logic        clk;
    logic        rst_i;
    logic        valid_i;
    logic [31:0] ins_addr_i;
    logic [6:0]  opcode_i;
    logic [2:0]  funct3_i;
    logic [6:0]  funct7_i;
    logic [31:0] imm_i;
    logic [31:0] rs1_data_i;
    logic [31:0] rs2_data_i;
    logic [4:0]  rd_addr_i;
    logic [31:0] mem_rd_addr_i;
    logic [31:0] mem_rd_data_i;
    logic        reg_wr_en_o;
    logic [4:0]  reg_wr_addr_o;
    logic [31:0] reg_wr_data_o;
    logic        jump_flag_o;
    logic [31:0] jump_addr_o;

    int     checks;
    int     errors;
    int     cycles;
    integer seed;

    exec_unit dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: tests still running after %0d cycles", max_cycles);
            $display("sim failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // reference model, straight from the RV32I rules
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  alu_ref = alt ? a - b : a + b;
            3'b001:  alu_ref = a << b[4:0];
            3'b010:  alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  alu_ref = (a < b) ? 32'd1 : 32'd0;
            3'b100:  alu_ref = a ^ b;
            3'b101:  alu_ref = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  alu_ref = a | b;
            default: alu_ref = a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'b000:  branch_ref = (a == b);
            3'b001:  branch_ref = (a != b);
            3'b100:  branch_ref = ($signed(a) < $signed(b));
            3'b101:  branch_ref = ($signed(a) >= $signed(b));
            3'b110:  branch_ref = (a < b);
            default: branch_ref = (a >= b);
        endcase
    endfunction

    function automatic logic [31:0] load_ref(input logic [2:0] f3, input logic [1:0] off,
                                             input logic [31:0] w);
        logic [31:0] sh;
        logic [15:0] h;
        sh = w >> (8 * off);
        h  = (off == 2'd0) ? w[15:0] : w[31:16];
        case (f3)
            3'b000:  load_ref = {{24{sh[7]}}, sh[7:0]};
            3'b100:  load_ref = {24'd0, sh[7:0]};
            3'b001:  load_ref = {{16{h[15]}}, h};
            3'b101:  load_ref = {16'd0, h};
            default: load_ref = w;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // one instruction in, result checked one cycle later
    task automatic step_and_check(input logic exp_wr, input logic [31:0] exp_data,
                                  input logic exp_jmp, input logic [31:0] exp_addr);
        valid_i = 1'b1;
        @(negedge clk);
        valid_i = 1'b0;
        check("reg_wr_en_o", 32'(reg_wr_en_o), 32'(exp_wr));
        check("jump_flag_o", 32'(jump_flag_o), 32'(exp_jmp));
        if (exp_wr) begin
            check("reg_wr_addr_o", 32'(reg_wr_addr_o), 32'(rd_addr_i));
            check("reg_wr_data_o", reg_wr_data_o, exp_data);
        end
        if (exp_jmp) begin
            check("jump_addr_o", jump_addr_o, exp_addr);
        end
    endtask

    // idle cycle, then the summary line of the test
    task automatic finish_test(input string name, input int errs_before);
        @(negedge clk);
        check("reg_wr_en_o", 32'(reg_wr_en_o), 32'd0);
        check("jump_flag_o", 32'(jump_flag_o), 32'd0);
        $display("test %s done, %0d errors", name, errors - errs_before);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////
    task automatic test_reset_idle();
        int errs;
        errs = errors;
        check("reg_wr_en_o", 32'(reg_wr_en_o), 32'd0);
        check("jump_flag_o", 32'(jump_flag_o), 32'd0);
        check("reg_wr_addr_o", 32'(reg_wr_addr_o), 32'd0);
        check("reg_wr_data_o", reg_wr_data_o, 32'd0);
        check("jump_addr_o", jump_addr_o, 32'd0);
        // jal held with valid low
        opcode_i = exec_pkg::opc_jal;
        @(negedge clk);
        check("reg_wr_en_o", 32'(reg_wr_en_o), 32'd0);
        check("jump_flag_o", 32'(jump_flag_o), 32'd0);
        opcode_i = 7'b1111111;
        step_and_check(1'b0, 32'd0, 1'b0, 32'd0);
        finish_test("reset_idle", errs);
    endtask

    task automatic test_alu();
        int          errs;
        logic [31:0] r;
        logic [2:0]  f3;
        logic        is_op;
        logic        alt;
        errs = errors;
        for (int i = 0; i < 40; i++) begin
            f3    = i[2:0];
            is_op = i[4];
            alt   = i[3] && (f3 == 3'b101 || (is_op && f3 == 3'b000));
            r          = $random(seed);
            rd_addr_i  = r[4:0];
            rs1_data_i = $random(seed);
            rs2_data_i = $random(seed);
            imm_i      = $random(seed);
            opcode_i   = is_op ? exec_pkg::opc_op : exec_pkg::opc_op_imm;
            funct3_i   = f3;
            funct7_i   = alt ? exec_pkg::f7_alt : 7'd0;
            step_and_check(1'b1, alu_ref(f3, alt, rs1_data_i, is_op ? rs2_data_i : imm_i),
                           1'b0, 32'd0);
        end
        // illegal funct7 on a shift and on OP
        opcode_i = exec_pkg::opc_op_imm;
        funct3_i = 3'b001;
        funct7_i = exec_pkg::f7_alt;
        step_and_check(1'b0, 32'd0, 1'b0, 32'd0);
        opcode_i = exec_pkg::opc_op;
        funct3_i = 3'b101;
        funct7_i = 7'b0000001;
        step_and_check(1'b0, 32'd0, 1'b0, 32'd0);
        finish_test("alu", errs);
    endtask

    task automatic test_upper();
        int          errs;
        logic [31:0] r;
        errs = errors;
        r          = $random(seed);
        imm_i      = {r[31:12], 12'd0};
        ins_addr_i = {r[23:2], 2'b00, 8'd0};
        rs1_data_i = $random(seed);
        rd_addr_i  = r[4:0];
        funct7_i   = 7'd0;
        opcode_i   = exec_pkg::opc_lui;
        step_and_check(1'b1, imm_i, 1'b0, 32'd0);
        opcode_i   = exec_pkg::opc_auipc;
        step_and_check(1'b1, ins_addr_i + imm_i, 1'b0, 32'd0);
        finish_test("lui_auipc", errs);
    endtask

    task automatic test_jumps();
        int          errs;
        logic [31:0] r;
        errs = errors;
        r          = $random(seed);
        ins_addr_i = {r[31:2], 2'b00};
        imm_i      = $random(seed);
        rs1_data_i = $random(seed);
        rd_addr_i  = r[6:2];
        opcode_i   = exec_pkg::opc_jal;
        step_and_check(1'b1, ins_addr_i + 32'd4, 1'b1, ins_addr_i + imm_i);
        opcode_i   = exec_pkg::opc_jalr;
        funct3_i   = 3'b000;
        step_and_check(1'b1, ins_addr_i + 32'd4, 1'b1, rs1_data_i + imm_i);
        finish_test("jal_jalr", errs);
    endtask

    task automatic test_branches();
        int          errs;
        logic [31:0] r;
        errs = errors;
        opcode_i = exec_pkg::opc_branch;
        funct7_i = 7'd0;
        for (int j = 0; j < 8; j++) begin
            if (j == 2 || j == 3) begin
                continue;
            end
            for (int k = 0; k < 3; k++) begin
                r          = $random(seed);
                ins_addr_i = {r[31:2], 2'b00};
                imm_i      = $random(seed);
                rs1_data_i = $random(seed);
                // equal, random, then opposite signs
                rs2_data_i = (k == 0) ? rs1_data_i : $random(seed);
                if (k == 2) begin
                    rs2_data_i = {~rs1_data_i[31], rs2_data_i[30:0]};
                end
                funct3_i = j[2:0];
                step_and_check(1'b0, 32'd0, branch_ref(j[2:0], rs1_data_i, rs2_data_i),
                               ins_addr_i + imm_i);
            end
        end
        finish_test("branches", errs);
    endtask

    task automatic test_loads();
        int          errs;
        logic [31:0] r;
        errs = errors;
        opcode_i = exec_pkg::opc_load;
        for (int j = 0; j < 6; j++) begin
            if (j == 3) begin
                continue;
            end
            for (int off = 0; off < 4; off++) begin
                r             = $random(seed);
                rd_addr_i     = r[4:0];
                mem_rd_addr_i = {r[31:2], off[1:0]};
                mem_rd_data_i = $random(seed);
                funct3_i      = j[2:0];
                step_and_check(1'b1, load_ref(j[2:0], off[1:0], mem_rd_data_i), 1'b0, 32'd0);
            end
        end
        finish_test("loads", errs);
    endtask

    initial begin
        seed          = 32'hf3ca1f09;
        checks        = 0;
        errors        = 0;
        cycles        = 0;
        rst_i         = 1'b1;
        valid_i       = 1'b0;
        ins_addr_i    = '0;
        opcode_i      = '0;
        funct3_i      = '0;
        funct7_i      = '0;
        imm_i         = '0;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        rd_addr_i     = '0;
        mem_rd_addr_i = '0;
        mem_rd_data_i = '0;
        repeat (10) @(negedge clk);
        rst_i = 1'b0;
        @(negedge clk);
        test_reset_idle();
        test_alu();
        test_upper();
        test_jumps();
        test_branches();
        test_loads();
        $display("checks: %0d passed, %0d failed", checks - errors, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* tests/exec_checker.sv */
`timescale 1ns/1ps

module exec_checker (
    input logic                         clk,
    input logic                         rst_i,
    input logic                         valid_i,
    input logic [exec_pkg::opc_w-1:0]   opcode_i,
    input logic                         wr_en_i,
    input logic                         jump_flag_i
);

    // outputs are idle right after a reset cycle
    assert property (@(posedge clk) rst_i |=> (!wr_en_i && !jump_flag_i))
        else $error("write or jump active after reset");

    // nothing comes out without an accepted instruction
    assert property (@(posedge clk) disable iff (rst_i)
        (wr_en_i || jump_flag_i) |-> $past(valid_i))
        else $error("output active without valid one cycle earlier");

    // only jal and jalr both write and jump
    assert property (@(posedge clk) disable iff (rst_i)
        jump_flag_i |-> (!wr_en_i || $past(opcode_i) == exec_pkg::opc_jal ||
                         $past(opcode_i) == exec_pkg::opc_jalr))
        else $error("jump with register write from a non-link instruction");

endmodule

bind exec_unit exec_checker checker_i (
    .clk(clk), .rst_i(rst_i), .valid_i(valid_i), .opcode_i(opcode_i),
    .wr_en_i(reg_wr_en_o), .jump_flag_i(jump_flag_o)
);

/* rtl/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              valid_i,
    input  logic [exec_pkg::xlen-1:0]         ins_addr_i,
    input  logic [exec_pkg::opc_w-1:0]        opcode_i,
    input  logic [exec_pkg::f3_w-1:0]         funct3_i,
    input  logic [exec_pkg::f7_w-1:0]         funct7_i,
    input  logic [exec_pkg::xlen-1:0]         imm_i,
    input  logic [exec_pkg::xlen-1:0]         rs1_data_i,
    input  logic [exec_pkg::xlen-1:0]         rs2_data_i,
    input  logic [exec_pkg::reg_addr_w-1:0]   rd_addr_i,
    input  logic [exec_pkg::xlen-1:0]         mem_rd_addr_i,
    input  logic [exec_pkg::xlen-1:0]         mem_rd_data_i,
    output logic                              reg_wr_en_o,
    output logic [exec_pkg::reg_addr_w-1:0]   reg_wr_addr_o,
    output logic [exec_pkg::xlen-1:0]         reg_wr_data_o,
    output logic                              jump_flag_o,
    output logic [exec_pkg::xlen-1:0]         jump_addr_o
);

    exec_pkg::alu_op_e          alu_op;
    logic [exec_pkg::xlen-1:0]  alu_a;
    logic [exec_pkg::xlen-1:0]  alu_b;
    logic [exec_pkg::xlen-1:0]  alu_res;
    logic                       alu_zero;
    exec_pkg::jump_kind_e       jump_kind;
    logic                       jump_taken;
    logic [exec_pkg::xlen-1:0]  jump_target;
    logic [exec_pkg::xlen-1:0]  link_addr;
    exec_pkg::load_kind_e       load_kind;
    logic [exec_pkg::xlen-1:0]  load_data;

    exec_ctrl ctrl_i (
        .clk(clk), .rst_i(rst_i), .valid_i(valid_i),
        .ins_addr_i(ins_addr_i), .opcode_i(opcode_i),
        .funct3_i(funct3_i), .funct7_i(funct7_i), .imm_i(imm_i),
        .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i), .rd_addr_i(rd_addr_i),
        .alu_res_i(alu_res), .jump_taken_i(jump_taken),
        .jump_target_i(jump_target), .link_addr_i(link_addr), .load_data_i(load_data),
        .alu_op_o(alu_op), .alu_a_o(alu_a), .alu_b_o(alu_b),
        .jump_kind_o(jump_kind), .load_kind_o(load_kind),
        .reg_wr_en_o(reg_wr_en_o), .reg_wr_addr_o(reg_wr_addr_o),
        .reg_wr_data_o(reg_wr_data_o),
        .jump_flag_o(jump_flag_o), .jump_addr_o(jump_addr_o)
    );

    exec_alu alu_i (
        .op_i(alu_op), .a_i(alu_a), .b_i(alu_b),
        .res_o(alu_res), .zero_o(alu_zero)
    );

    branch_resolve branch_i (
        .kind_i(jump_kind), .pc_i(ins_addr_i), .imm_i(imm_i),
        .alu_res_i(alu_res), .alu_zero_i(alu_zero),
        .taken_o(jump_taken), .target_o(jump_target), .link_o(link_addr)
    );

    load_align load_i (
        .kind_i(load_kind), .addr_i(mem_rd_addr_i), .data_i(mem_rd_data_i),
        .data_o(load_data)
    );

endmodule

/* rtl/exec_ctrl.sv */
`timescale 1ns/1ps

module exec_ctrl (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              valid_i,
    input  logic [exec_pkg::xlen-1:0]         ins_addr_i,
    input  logic [exec_pkg::opc_w-1:0]        opcode_i,
    input  logic [exec_pkg::f3_w-1:0]         funct3_i,
    input  logic [exec_pkg::f7_w-1:0]         funct7_i,
    input  logic [exec_pkg::xlen-1:0]         imm_i,
    input  logic [exec_pkg::xlen-1:0]         rs1_data_i,
    input  logic [exec_pkg::xlen-1:0]         rs2_data_i,
    input  logic [exec_pkg::reg_addr_w-1:0]   rd_addr_i,
    input  logic [exec_pkg::xlen-1:0]         alu_res_i,
    input  logic                              jump_taken_i,
    input  logic [exec_pkg::xlen-1:0]         jump_target_i,
    input  logic [exec_pkg::xlen-1:0]         link_addr_i,
    input  logic [exec_pkg::xlen-1:0]         load_data_i,
    output exec_pkg::alu_op_e                 alu_op_o,
    output logic [exec_pkg::xlen-1:0]         alu_a_o,
    output logic [exec_pkg::xlen-1:0]         alu_b_o,
    output exec_pkg::jump_kind_e              jump_kind_o,
    output exec_pkg::load_kind_e              load_kind_o,
    output logic                              reg_wr_en_o,
    output logic [exec_pkg::reg_addr_w-1:0]   reg_wr_addr_o,
    output logic [exec_pkg::xlen-1:0]         reg_wr_data_o,
    output logic                              jump_flag_o,
    output logic [exec_pkg::xlen-1:0]         jump_addr_o
);

    exec_pkg::wb_sel_e          wb_sel;
    logic                       wr_en;
    logic                       f7_zero;
    logic                       f7_is_alt;
    logic [exec_pkg::xlen-1:0]  wb_data;

    // funct3 to alu op, alt picks sub / sra
    function automatic exec_pkg::alu_op_e arith_op(input logic [exec_pkg::f3_w-1:0] f3,
                                                   input logic alt);
        case (f3)
            exec_pkg::f3_add:  return alt ? exec_pkg::alu_sub : exec_pkg::alu_add;
            exec_pkg::f3_sll:  return exec_pkg::alu_sll;
            exec_pkg::f3_slt:  return exec_pkg::alu_slt;
            exec_pkg::f3_sltu: return exec_pkg::alu_sltu;
            exec_pkg::f3_xor:  return exec_pkg::alu_xor;
            exec_pkg::f3_sr:   return alt ? exec_pkg::alu_sra : exec_pkg::alu_srl;
            exec_pkg::f3_or:   return exec_pkg::alu_or;
            default:           return exec_pkg::alu_and;
        endcase
    endfunction

    assign f7_zero   = (funct7_i == '0);
    assign f7_is_alt = (funct7_i == exec_pkg::f7_alt);

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        alu_op_o    = exec_pkg::alu_add;
        alu_a_o     = rs1_data_i;
        alu_b_o     = imm_i;
        jump_kind_o = exec_pkg::jmp_none;
        load_kind_o = exec_pkg::ld_w;
        wb_sel      = exec_pkg::wb_alu;
        wr_en       = 1'b0;

        case (opcode_i)
            exec_pkg::opc_op_imm: begin
                alu_op_o = arith_op(funct3_i, f7_is_alt && (funct3_i == exec_pkg::f3_sr));
                // funct7 only constrains the shift forms
                if (funct3_i == exec_pkg::f3_sll) begin
                    wr_en = f7_zero;
                end else if (funct3_i == exec_pkg::f3_sr) begin
                    wr_en = f7_zero || f7_is_alt;
                end else begin
                    wr_en = 1'b1;
                end
            end
            exec_pkg::opc_op: begin
                alu_b_o  = rs2_data_i;
                alu_op_o = arith_op(funct3_i, f7_is_alt);
                wr_en    = f7_zero || (f7_is_alt && (funct3_i == exec_pkg::f3_add ||
                                                     funct3_i == exec_pkg::f3_sr));
            end
            exec_pkg::opc_lui: begin
                alu_a_o = '0;
                wr_en   = 1'b1;
            end
            exec_pkg::opc_auipc: begin
                alu_a_o = ins_addr_i;
                wr_en   = 1'b1;
            end
            exec_pkg::opc_jal: begin
                alu_a_o     = ins_addr_i;
                jump_kind_o = exec_pkg::jmp_always;
                wb_sel      = exec_pkg::wb_link;
                wr_en       = 1'b1;
            end
            exec_pkg::opc_jalr: begin
                jump_kind_o = exec_pkg::jmp_always;
                wb_sel      = exec_pkg::wb_link;
                wr_en       = 1'b1;
            end
            exec_pkg::opc_branch: begin
                alu_b_o = rs2_data_i;
                case (funct3_i)
                    exec_pkg::f3_beq: begin
                        alu_op_o    = exec_pkg::alu_sub;
                        jump_kind_o = exec_pkg::jmp_if_zero;
                    end
                    exec_pkg::f3_bne: begin
                        alu_op_o    = exec_pkg::alu_sub;
                        jump_kind_o = exec_pkg::jmp_if_nonzero;
                    end
                    exec_pkg::f3_blt: begin
                        alu_op_o    = exec_pkg::alu_slt;
                        jump_kind_o = exec_pkg::jmp_if_nonzero;
                    end
                    exec_pkg::f3_bge: begin
                        alu_op_o    = exec_pkg::alu_slt;
                        jump_kind_o = exec_pkg::jmp_if_zero;
                    end
                    exec_pkg::f3_bltu: begin
                        alu_op_o    = exec_pkg::alu_sltu;
                        jump_kind_o = exec_pkg::jmp_if_nonzero;
                    end
                    exec_pkg::f3_bgeu: begin
                        alu_op_o    = exec_pkg::alu_sltu;
                        jump_kind_o = exec_pkg::jmp_if_zero;
                    end
                    default: jump_kind_o = exec_pkg::jmp_none;
                endcase
            end
            exec_pkg::opc_load: begin
                wb_sel = exec_pkg::wb_load;
                wr_en  = 1'b1;
                case (funct3_i)
                    exec_pkg::f3_lb:  load_kind_o = exec_pkg::ld_b;
                    exec_pkg::f3_lh:  load_kind_o = exec_pkg::ld_h;
                    exec_pkg::f3_lw:  load_kind_o = exec_pkg::ld_w;
                    exec_pkg::f3_lbu: load_kind_o = exec_pkg::ld_bu;
                    exec_pkg::f3_lhu: load_kind_o = exec_pkg::ld_hu;
                    default:          wr_en = 1'b0;
                endcase
            end
            default: wr_en = 1'b0;
        endcase
    end

    // write-back source
    always_comb begin
        case (wb_sel)
            exec_pkg::wb_link: wb_data = link_addr_i;
            exec_pkg::wb_load: wb_data = load_data_i;
            default:           wb_data = alu_res_i;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_i) begin
            reg_wr_en_o   <= 1'b0;
            reg_wr_addr_o <= '0;
            reg_wr_data_o <= '0;
            jump_flag_o   <= 1'b0;
            jump_addr_o   <= '0;
        end else begin
            reg_wr_en_o <= valid_i && wr_en;
            jump_flag_o <= valid_i && jump_taken_i;
            // payload holds while idle
            if (valid_i) begin
                reg_wr_addr_o <= rd_addr_i;
                reg_wr_data_o <= wb_data;
                jump_addr_o   <= jump_target_i;
            end
        end
    end

endmodule

/* rtl/load_align.sv */
`timescale 1ns/1ps

module load_align (
    input  exec_pkg::load_kind_e        kind_i,
    input  logic [exec_pkg::xlen-1:0]   addr_i,
    input  logic [exec_pkg::xlen-1:0]   data_i,
    output logic [exec_pkg::xlen-1:0]   data_o
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // byte lane from the low address bits
    always_comb begin
        case (addr_i[1:0])
            2'b00:   byte_lane = data_i[7:0];
            2'b01:   byte_lane = data_i[15:8];
            2'b10:   byte_lane = data_i[23:16];
            default: byte_lane = data_i[31:24];
        endcase
    end

    // any nonzero offset takes the upper half
    assign half_lane = (addr_i[1:0] == 2'b00) ? data_i[15:0] : data_i[31:16];

    always_comb begin
        case (kind_i)
            exec_pkg::ld_b:  data_o = {{24{byte_lane[7]}}, byte_lane};
            exec_pkg::ld_bu: data_o = {24'd0, byte_lane};
            exec_pkg::ld_h:  data_o = {{16{half_lane[15]}}, half_lane};
            exec_pkg::ld_hu: data_o = {16'd0, half_lane};
            default:         data_o = data_i;
        endcase
    end

endmodule

/* rtl/branch_resolve.sv */
`timescale 1ns/1ps

module branch_resolve (
    input  exec_pkg::jump_kind_e        kind_i,
    input  logic [exec_pkg::xlen-1:0]   pc_i,
    input  logic [exec_pkg::xlen-1:0]   imm_i,
    input  logic [exec_pkg::xlen-1:0]   alu_res_i,
    input  logic                        alu_zero_i,
    output logic                        taken_o,
    output logic [exec_pkg::xlen-1:0]   target_o,
    output logic [exec_pkg::xlen-1:0]   link_o
);

    logic [exec_pkg::xlen-1:0] pc_rel;

    assign pc_rel = pc_i + imm_i;
    assign link_o = pc_i + exec_pkg::inst_len;

    always_comb begin
        target_o = pc_rel;
        case (kind_i)
            exec_pkg::jmp_always: begin
                // jal / jalr target comes out of the alu
                taken_o  = 1'b1;
                target_o = alu_res_i;
            end
            exec_pkg::jmp_if_zero:    taken_o = alu_zero_i;
            exec_pkg::jmp_if_nonzero: taken_o = !alu_zero_i;
            default:                  taken_o = 1'b0;
        endcase
    end

endmodule

/* rtl/exec_alu.sv */
`timescale 1ns/1ps

module exec_alu (
    input  exec_pkg::alu_op_e           op_i,
    input  logic [exec_pkg::xlen-1:0]   a_i,
    input  logic [exec_pkg::xlen-1:0]   b_i,
    output logic [exec_pkg::xlen-1:0]   res_o,
    output logic                        zero_o
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    // only the low five bits shift
    assign shamt = b_i[4:0];
    assign lt_s  = ($signed(a_i) < $signed(b_i));
    assign lt_u  = (a_i < b_i);

    always_comb begin
        case (op_i)
            exec_pkg::alu_add:  res_o = a_i + b_i;
            exec_pkg::alu_sub:  res_o = a_i - b_i;
            exec_pkg::alu_sll:  res_o = a_i << shamt;
            exec_pkg::alu_slt:  res_o = {{(exec_pkg::xlen-1){1'b0}}, lt_s};
            exec_pkg::alu_sltu: res_o = {{(exec_pkg::xlen-1){1'b0}}, lt_u};
            exec_pkg::alu_xor:  res_o = a_i ^ b_i;
            exec_pkg::alu_srl:  res_o = a_i >> shamt;
            exec_pkg::alu_sra:  res_o = $unsigned($signed(a_i) >>> shamt);
            exec_pkg::alu_or:   res_o = a_i | b_i;
            exec_pkg::alu_and:  res_o = a_i & b_i;
            default:            res_o = '0;
        endcase
    end

    // branches read their condition from this flag
    assign zero_o = (res_o == '0);

endmodule

/* rtl/exec_pkg.sv */
package exec_pkg;

    // datapath and field widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int opc_w      = 7;
    localparam int f3_w       = 3;
    localparam int f7_w       = 7;

    ////////////////////////////////////////////////////////////
    // opcodes
    ////////////////////////////////////////////////////////////
    localparam logic [opc_w-1:0] opc_op_imm = 7'b0010011;
    localparam logic [opc_w-1:0] opc_op     = 7'b0110011;
    localparam logic [opc_w-1:0] opc_lui    = 7'b0110111;
    localparam logic [opc_w-1:0] opc_auipc  = 7'b0010111;
    localparam logic [opc_w-1:0] opc_jal    = 7'b1101111;
    localparam logic [opc_w-1:0] opc_jalr   = 7'b1100111;
    localparam logic [opc_w-1:0] opc_branch = 7'b1100011;
    localparam logic [opc_w-1:0] opc_load   = 7'b0000011;

    // alu funct3, shared by OP and OP-IMM
    localparam logic [f3_w-1:0] f3_add  = 3'b000;
    localparam logic [f3_w-1:0] f3_sll  = 3'b001;
    localparam logic [f3_w-1:0] f3_slt  = 3'b010;
    localparam logic [f3_w-1:0] f3_sltu = 3'b011;
    localparam logic [f3_w-1:0] f3_xor  = 3'b100;
    localparam logic [f3_w-1:0] f3_sr   = 3'b101;
    localparam logic [f3_w-1:0] f3_or   = 3'b110;
    localparam logic [f3_w-1:0] f3_and  = 3'b111;

    // branch funct3
    localparam logic [f3_w-1:0] f3_beq  = 3'b000;
    localparam logic [f3_w-1:0] f3_bne  = 3'b001;
    localparam logic [f3_w-1:0] f3_blt  = 3'b100;
    localparam logic [f3_w-1:0] f3_bge  = 3'b101;
    localparam logic [f3_w-1:0] f3_bltu = 3'b110;
    localparam logic [f3_w-1:0] f3_bgeu = 3'b111;

    // load funct3
    localparam logic [f3_w-1:0] f3_lb  = 3'b000;
    localparam logic [f3_w-1:0] f3_lh  = 3'b001;
    localparam logic [f3_w-1:0] f3_lw  = 3'b010;
    localparam logic [f3_w-1:0] f3_lbu = 3'b100;
    localparam logic [f3_w-1:0] f3_lhu = 3'b101;

    // selects SUB and SRA
    localparam logic [f7_w-1:0] f7_alt = 7'b0100000;

    localparam logic [xlen-1:0] inst_len = 32'd4;

    ////////////////////////////////////////////////////////////
    // enums
    ////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic [1:0] {
        jmp_none, jmp_always, jmp_if_zero, jmp_if_nonzero
    } jump_kind_e;

    typedef enum logic [2:0] {
        ld_b, ld_h, ld_w, ld_bu, ld_hu
    } load_kind_e;

    typedef enum logic [1:0] {
        wb_alu, wb_link, wb_load
    } wb_sel_e;

endpackage
